//--- verilog/mem_agent_macros.svh
`ifndef MEM_AGENT_MACROS_SVH
`define MEM_AGENT_MACROS_SVH

// ####################
// Bus widths
// ####################
`define MEM_AGENT_DW 64 // Data width in bits
`define MEM_AGENT_AW 32 // Byte address width
`define MEM_AGENT_CW 32 // Command width

// Number of 64-bit words in the RAM
`define MEM_AGENT_RAMDEPTH 256

// ####################
// Command fields
// ####################
`define MEM_AGENT_CMD_OPCODE 4:0   // Transaction opcode
`define MEM_AGENT_CMD_SIZE   7:5   // Log2 of bytes per element
`define MEM_AGENT_CMD_LEN    15:8  // Element count minus one
`define MEM_AGENT_CMD_ATYPE  23:16 // Atomic operation, bits 31:24 stay zero

`endif

//--- verilog/umi_pkg.sv
`default_nettype none

package umi_pkg;

   // ####################
   // Opcodes
   // ####################
   typedef enum logic [4:0] {
      REQ_READ   = 5'h01,
      RESP_READ  = 5'h02,
      REQ_WRITE  = 5'h03,
      RESP_WRITE = 5'h04,
      REQ_POSTED = 5'h05, // Write without acknowledge
      REQ_ATOMIC = 5'h09
   } umi_opcode_e;

   // ####################
   // Atomic operations
   // ####################
   // Unlisted codes behave as swap
   typedef enum logic [7:0] {
      ATOMIC_ADD  = 8'h00,
      ATOMIC_AND  = 8'h01,
      ATOMIC_OR   = 8'h02,
      ATOMIC_XOR  = 8'h03,
      ATOMIC_MAX  = 8'h04, // Signed
      ATOMIC_MIN  = 8'h05, // Signed
      ATOMIC_MAXU = 8'h06,
      ATOMIC_MINU = 8'h07,
      ATOMIC_SWAP = 8'h08
   } umi_atype_e;

endpackage

`default_nettype wire

//--- verilog/loc_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

// One local memory access, endpoint to datapath
interface loc_if;
   import umi_pkg::*;

   logic                     access; // High in the acceptance cycle only
   logic                     write;
   logic                     atomic;
   umi_atype_e               atype;
   logic [`MEM_AGENT_AW-1:0] addr;   // Byte address
   logic [2:0]               size;
   logic [7:0]               len;
   logic [`MEM_AGENT_DW-1:0] wrdata; // Right-aligned
   logic [`MEM_AGENT_DW-1:0] rddata; // Right-aligned, one cycle after access
   logic                     ready;  // Low during atomic write-back

   modport ep (
      output access, write, atomic, atype, addr, size, len, wrdata,
      input  rddata, ready
   );

   modport dp (
      input  access, write, atomic, atype, addr, size, len, wrdata,
      output rddata, ready
   );

endinterface

`default_nettype wire

//--- verilog/umi_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

module umi_endpoint (
   input  logic                     clk,
   input  logic                     nreset,
   // Request channel
   input  logic                     req_valid,
   input  logic [`MEM_AGENT_CW-1:0] req_cmd,
   input  logic [`MEM_AGENT_AW-1:0] req_dstaddr,
   input  logic [`MEM_AGENT_AW-1:0] req_srcaddr,
   input  logic [`MEM_AGENT_DW-1:0] req_data,
   output logic                     req_ready,
   // Response channel
   output logic                     resp_valid,
   output logic [`MEM_AGENT_CW-1:0] resp_cmd,
   output logic [`MEM_AGENT_AW-1:0] resp_dstaddr,
   output logic [`MEM_AGENT_AW-1:0] resp_srcaddr,
   output logic [`MEM_AGENT_DW-1:0] resp_data,
   input  logic                     resp_ready,
   // Local access
   loc_if.ep                        loc
);
   import umi_pkg::*;

   logic                     accept;
   logic                     resp_load;  // Response register free at next edge
   umi_opcode_e              req_opcode;

   // Item in the memory stage
   logic                     pend_valid; // Response owed
   logic                     pend_hold;  // Read data parked in pend_data
   umi_opcode_e              pend_opcode;
   logic [`MEM_AGENT_AW-1:0] pend_dstaddr;
   logic [`MEM_AGENT_AW-1:0] pend_srcaddr;
   logic [2:0]               pend_size;
   logic [7:0]               pend_len;
   logic [`MEM_AGENT_DW-1:0] pend_data;
   logic [`MEM_AGENT_DW-1:0] pend_rddata;
   logic [`MEM_AGENT_CW-1:0] resp_cmd_next;

   // ####################
   // Request decode
   // ####################
   assign req_opcode = umi_opcode_e'(req_cmd[`MEM_AGENT_CMD_OPCODE]);
   assign resp_load  = !resp_valid || resp_ready;
   assign req_ready  = loc.ready && resp_load;
   assign accept     = req_valid && req_ready;

   assign loc.access = accept;
   assign loc.write  = (req_opcode == REQ_WRITE) || (req_opcode == REQ_POSTED);
   assign loc.atomic = (req_opcode == REQ_ATOMIC);
   assign loc.atype  = umi_atype_e'(req_cmd[`MEM_AGENT_CMD_ATYPE]);
   assign loc.addr   = req_dstaddr;
   assign loc.size   = req_cmd[`MEM_AGENT_CMD_SIZE];
   assign loc.len    = req_cmd[`MEM_AGENT_CMD_LEN];
   assign loc.wrdata = req_data;

   // ####################
   // Pending record
   // ####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         pend_valid <= 1'b0;
         pend_hold  <= 1'b0;
      end else begin
         if (accept)
            pend_valid <= (req_opcode != REQ_POSTED); // Posted writes owe nothing
         else if (resp_load)
            pend_valid <= 1'b0;
         pend_hold <= pend_valid && !resp_load; // Stalled behind a full response
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         pend_opcode  <= (req_opcode == REQ_WRITE) ? RESP_WRITE : RESP_READ;
         pend_dstaddr <= req_srcaddr; // Response goes back to the requester
         pend_srcaddr <= req_dstaddr;
         pend_size    <= req_cmd[`MEM_AGENT_CMD_SIZE];
         pend_len     <= req_cmd[`MEM_AGENT_CMD_LEN];
      end
      // RAM output only lasts one cycle
      if (pend_valid && !pend_hold)
         pend_data <= loc.rddata;
   end

   assign pend_rddata = pend_hold ? pend_data : loc.rddata;

   always_comb begin
      resp_cmd_next = '0;
      resp_cmd_next[`MEM_AGENT_CMD_OPCODE] = pend_opcode;
      resp_cmd_next[`MEM_AGENT_CMD_SIZE]   = pend_size;
      resp_cmd_next[`MEM_AGENT_CMD_LEN]    = pend_len;
   end

   // ####################
   // Response register
   // ####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         resp_valid <= 1'b0;
      else if (resp_load)
         resp_valid <= pend_valid;
   end

   always_ff @(posedge clk) begin
      if (resp_load && pend_valid) begin
         resp_cmd     <= resp_cmd_next;
         resp_dstaddr <= pend_dstaddr;
         resp_srcaddr <= pend_srcaddr;
         // Write acks carry no data
         resp_data    <= (pend_opcode == RESP_READ) ? pend_rddata : '0;
      end
   end

endmodule

`default_nettype wire

//--- verilog/mem_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

module mem_datapath (
   input  logic                       clk,
   input  logic                       nreset,
   loc_if.dp                          loc,
   // RAM port
   output logic                       mem_we,
   output logic [`MEM_AGENT_AW-4:0]   mem_addr,  // Word index
   output logic [`MEM_AGENT_DW/8-1:0] mem_wmask, // One bit per byte
   output logic [`MEM_AGENT_DW-1:0]   mem_din,
   input  logic [`MEM_AGENT_DW-1:0]   mem_dout
);
   import umi_pkg::*;

   logic [2:0]                 offset;   // Byte lane of the first byte
   logic [11:0]                lenp1;
   logic [11:0]                nbytes;
   logic [11:0]                end_byte; // One past the last byte
   logic [`MEM_AGENT_DW/8-1:0] byte_mask;
   logic [`MEM_AGENT_DW-1:0]   wr_aligned;

   // Atomic state, captured in the acceptance cycle
   logic                       atom_busy;
   logic [`MEM_AGENT_AW-4:0]   atom_addr;
   logic [`MEM_AGENT_DW/8-1:0] atom_mask;
   umi_atype_e                 atom_type;
   logic [`MEM_AGENT_DW-1:0]   atom_operand; // Element top at bit 63
   logic [6:0]                 atom_shift;
   logic [`MEM_AGENT_DW-1:0]   old_msb;
   logic [`MEM_AGENT_DW-1:0]   atom_result;
   logic [2:0]                 rd_offset;

   // ####################
   // Byte mask and lanes
   // ####################
   assign offset     = loc.addr[2:0];
   assign lenp1      = {4'h0, loc.len} + 12'd1;
   assign nbytes     = lenp1 << loc.size;
   assign end_byte   = {9'h0, offset} + nbytes;
   assign wr_aligned = loc.wrdata << {offset, 3'b000};

   always_comb begin
      for (int i = 0; i < `MEM_AGENT_DW/8; i++) begin
         byte_mask[i] = (12'(i) >= {9'h0, offset}) && (12'(i) < end_byte);
      end
   end

   // ####################
   // Atomic sequencing
   // ####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         atom_busy <= 1'b0;
      else
         atom_busy <= loc.access && loc.atomic; // Write-back next cycle
   end

   always_ff @(posedge clk) begin
      if (loc.access && loc.atomic) begin
         atom_addr    <= loc.addr[`MEM_AGENT_AW-1:3];
         atom_mask    <= byte_mask;
         atom_type    <= loc.atype;
         atom_operand <= loc.wrdata << {4'd8 - nbytes[3:0], 3'b000};
         atom_shift   <= {4'd8 - end_byte[3:0], 3'b000};
      end
      rd_offset <= offset;
   end

   // Old element moved to the top so signed compares see its sign bit
   assign old_msb = mem_dout << atom_shift;

   always_comb begin
      case (atom_type)
         ATOMIC_ADD:  atom_result = atom_operand + old_msb;
         ATOMIC_AND:  atom_result = atom_operand & old_msb;
         ATOMIC_OR:   atom_result = atom_operand | old_msb;
         ATOMIC_XOR:  atom_result = atom_operand ^ old_msb;
         ATOMIC_MAX:
            atom_result = ($signed(atom_operand) > $signed(old_msb)) ? atom_operand : old_msb;
         ATOMIC_MIN:
            atom_result = ($signed(atom_operand) > $signed(old_msb)) ? old_msb : atom_operand;
         ATOMIC_MAXU: atom_result = (atom_operand > old_msb) ? atom_operand : old_msb;
         ATOMIC_MINU: atom_result = (atom_operand > old_msb) ? old_msb : atom_operand;
         default:     atom_result = atom_operand; // Swap
      endcase
   end

   // ####################
   // RAM port mux
   // ####################
   assign mem_we    = (loc.access && loc.write) || atom_busy;
   assign mem_addr  = atom_busy ? atom_addr : loc.addr[`MEM_AGENT_AW-1:3];
   assign mem_wmask = atom_busy ? atom_mask : byte_mask;
   assign mem_din   = atom_busy ? (atom_result >> atom_shift) : wr_aligned;

   assign loc.ready  = !atom_busy;
   assign loc.rddata = mem_dout >> {rd_offset, 3'b000}; // Right-aligned

endmodule

`default_nettype wire

//--- verilog/mem_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

module mem_array #(
   parameter int RAMDEPTH = `MEM_AGENT_RAMDEPTH
) (
   input  logic                        clk,
   input  logic                        we,
   input  logic [$clog2(RAMDEPTH)-1:0] addr,
   input  logic [`MEM_AGENT_DW/8-1:0]  wmask,
   input  logic [`MEM_AGENT_DW-1:0]    din,
   output logic [`MEM_AGENT_DW-1:0]    dout
);

   logic [`MEM_AGENT_DW-1:0] mem [RAMDEPTH];

   // Read returns the contents from before this edge's write
   always_ff @(posedge clk) begin
      dout <= mem[addr];
      if (we) begin
         for (int i = 0; i < `MEM_AGENT_DW/8; i++) begin
            if (wmask[i])
               mem[addr][i*8 +: 8] <= din[i*8 +: 8];
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/mem_agent.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

module mem_agent #(
   parameter int RAMDEPTH = `MEM_AGENT_RAMDEPTH
) (
   input  logic                     clk,
   input  logic                     nreset,
   // Request channel
   input  logic                     req_valid,
   input  logic [`MEM_AGENT_CW-1:0] req_cmd,
   input  logic [`MEM_AGENT_AW-1:0] req_dstaddr,
   input  logic [`MEM_AGENT_AW-1:0] req_srcaddr,
   input  logic [`MEM_AGENT_DW-1:0] req_data,
   output logic                     req_ready,
   // Response channel
   output logic                     resp_valid,
   output logic [`MEM_AGENT_CW-1:0] resp_cmd,
   output logic [`MEM_AGENT_AW-1:0] resp_dstaddr,
   output logic [`MEM_AGENT_AW-1:0] resp_srcaddr,
   output logic [`MEM_AGENT_DW-1:0] resp_data,
   input  logic                     resp_ready
);

   logic                       mem_we;
   logic [`MEM_AGENT_AW-4:0]   mem_addr; // Only the low bits reach the RAM
   logic [`MEM_AGENT_DW/8-1:0] mem_wmask;
   logic [`MEM_AGENT_DW-1:0]   mem_din;
   logic [`MEM_AGENT_DW-1:0]   mem_dout;

   loc_if loc_bus ();

   umi_endpoint endpoint_inst (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .loc          (loc_bus.ep)
   );

   mem_datapath datapath_inst (
      .clk       (clk),
      .nreset    (nreset),
      .loc       (loc_bus.dp),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wmask (mem_wmask),
      .mem_din   (mem_din),
      .mem_dout  (mem_dout)
   );

   mem_array #(
      .RAMDEPTH (RAMDEPTH)
   ) array_inst (
      .clk   (clk),
      .we    (mem_we),
      .addr  (mem_addr[$clog2(RAMDEPTH)-1:0]),
      .wmask (mem_wmask),
      .din   (mem_din),
      .dout  (mem_dout)
   );

endmodule

`default_nettype wire

//--- testbench/tb_mem_agent.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_agent_macros.svh"

module tb_mem_agent;
   import umi_pkg::*;

   typedef struct packed {
      logic [`MEM_AGENT_CW-1:0] cmd;
      logic [`MEM_AGENT_AW-1:0] dst;
      logic [`MEM_AGENT_AW-1:0] src;
      logic [`MEM_AGENT_DW-1:0] data;
      logic [`MEM_AGENT_DW-1:0] mask; // Bytes that carry the element
   } resp_t;

   logic                     clk;
   logic                     nreset;
   logic                     req_valid;
   logic [`MEM_AGENT_CW-1:0] req_cmd;
   logic [`MEM_AGENT_AW-1:0] req_dstaddr;
   logic [`MEM_AGENT_AW-1:0] req_srcaddr;
   logic [`MEM_AGENT_DW-1:0] req_data;
   logic                     req_ready;
   logic                     resp_valid;
   logic [`MEM_AGENT_CW-1:0] resp_cmd;
   logic [`MEM_AGENT_AW-1:0] resp_dstaddr;
   logic [`MEM_AGENT_AW-1:0] resp_srcaddr;
   logic [`MEM_AGENT_DW-1:0] resp_data;
   logic                     resp_ready;

   logic [7:0] ref_mem [128]; // Byte model of words 0 to 15
   resp_t      exp_q [$];     // Expected responses in request order
   integer     seed = 32'h50df;
   int         errors = 0;
   int         checks = 0;
   int         txn_id = 0;
   logic       stall_en = 1'b0;

   mem_agent mem_agent_inst (.*);

   always #4 clk = ~clk;

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [63:0] rand64();
      logic [63:0] value;
      value[63:32] = $random(seed);
      value[31:0]  = $random(seed);
      return value;
   endfunction

   // ####################
   // Reference model
   // ####################
   function automatic logic [63:0] ref_response(
      input logic [4:0] opcode, input logic [7:0] atype, input logic [2:0] offset,
      input logic [2:0] size, input logic [7:0] len, input logic [63:0] wdata,
      input logic [63:0] old_word, output logic [63:0] new_word,
      output logic [63:0] data_mask);
      int          nbytes;
      int          top;    // Moves the element sign bit to bit 63
      logic [63:0] emask;
      logic [63:0] old_el;
      logic [63:0] op;
      logic [63:0] res;
      nbytes    = (int'(len) + 1) << size;
      emask     = (nbytes >= 8) ? '1 : (64'h1 << (nbytes * 8)) - 64'h1;
      old_el    = (old_word >> (offset * 8)) & emask;
      op        = wdata & emask;
      top       = 64 - nbytes * 8;
      new_word  = old_word;
      data_mask = emask;
      case (opcode)
         REQ_WRITE, REQ_POSTED: begin
            new_word  = (old_word & ~(emask << (offset * 8))) | (op << (offset * 8));
            data_mask = '1; // Ack data is all zero
            return 64'h0;
         end
         REQ_ATOMIC: begin
            case (atype)
               ATOMIC_ADD:  res = op + old_el;
               ATOMIC_AND:  res = op & old_el;
               ATOMIC_OR:   res = op | old_el;
               ATOMIC_XOR:  res = op ^ old_el;
               ATOMIC_MAX:  res = ($signed(op << top) > $signed(old_el << top)) ? op : old_el;
               ATOMIC_MIN:  res = ($signed(op << top) < $signed(old_el << top)) ? op : old_el;
               ATOMIC_MAXU: res = (op > old_el) ? op : old_el;
               ATOMIC_MINU: res = (op < old_el) ? op : old_el;
               default:     res = op; // Swap and unknown codes
            endcase
            new_word = (old_word & ~(emask << (offset * 8))) | ((res & emask) << (offset * 8));
         end
         default: ;
      endcase
      return old_el;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Called at the acceptance edge, with the request still on the inputs
   task automatic record_request();
      logic [63:0] old_word;
      logic [63:0] new_word;
      logic [63:0] data_mask;
      logic [4:0]  opcode;
      int          base;
      resp_t       exp;
      opcode = req_cmd[`MEM_AGENT_CMD_OPCODE];
      base   = int'(req_dstaddr[6:3]) * 8;
      for (int i = 0; i < 8; i++)
         old_word[i*8 +: 8] = ref_mem[base + i];
      exp.data = ref_response(opcode, req_cmd[`MEM_AGENT_CMD_ATYPE], req_dstaddr[2:0],
                              req_cmd[`MEM_AGENT_CMD_SIZE], req_cmd[`MEM_AGENT_CMD_LEN],
                              req_data, old_word, new_word, data_mask);
      for (int i = 0; i < 8; i++)
         ref_mem[base + i] = new_word[i*8 +: 8];
      if (opcode != REQ_POSTED) begin
         exp.cmd  = {16'h0, req_cmd[15:5], (opcode == REQ_WRITE) ? RESP_WRITE : RESP_READ};
         exp.dst  = req_srcaddr;
         exp.src  = req_dstaddr;
         exp.mask = data_mask;
         exp_q.push_back(exp);
      end
   endtask

   // ####################
   // Stimulus helpers
   // ####################
   task automatic next_cycle();
      @(posedge clk);
      #1;
      resp_ready = stall_en ? (rand_below(2) == 0) : 1'b1;
   endtask

   task automatic send_req(input logic [4:0] opcode, input logic [7:0] atype,
                           input logic [31:0] addr, input logic [2:0] size,
                           input logic [7:0] len, input logic [63:0] data);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      txn_id++;
      req_valid   = 1'b1;
      req_cmd     = {8'h00, atype, len, size, opcode};
      req_dstaddr = addr;
      req_srcaddr = 32'ha000_0000 + 32'(txn_id); // Tags the request
      req_data    = data;
      while (!done && waited < 100) begin
         #1; // Ready is settled until the edge
         if (req_ready) begin
            done = 1'b1;
            record_request();
         end
         next_cycle();
         waited++;
      end
      req_valid = 1'b0;
      if (!done) begin
         errors++;
         $display("Request to address %h was not accepted within 100 cycles", addr);
      end
   endtask

   task automatic pick_span(output logic [2:0] size, output logic [7:0] len,
                            output logic [2:0] offset);
      int nbytes;
      size   = 3'(rand_below(4));
      len    = 8'(rand_below(8 >> size));
      nbytes = (int'(len) + 1) << size;
      offset = 3'(rand_below(9 - nbytes)); // Stays inside the word
   endtask

   task automatic send_atomic(input logic [7:0] atype);
      logic [2:0] size;
      logic [2:0] offset;
      size   = 3'(rand_below(4));
      offset = 3'(rand_below(8 >> size) << size); // Naturally aligned
      send_req(REQ_ATOMIC, atype, 32'(rand_below(16) * 8 + offset), size, 8'd0, rand64());
   endtask

   task automatic read_all();
      for (int w = 0; w < 16; w++)
         send_req(REQ_READ, 8'h00, 32'(w * 8), 3'd3, 8'd0, 64'h0);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 200) begin
         next_cycle();
         waited++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d expected responses never arrived", exp_q.size());
      end
   endtask

   // Samples between edges, where the response fields are stable
   always @(posedge clk) begin : response_monitor
      resp_t exp;
      #2;
      if (resp_valid === 1'b1 && resp_ready === 1'b1) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Response at %0t arrived with no request outstanding", $time);
         end else begin
            exp = exp_q.pop_front();
            check_value("resp_cmd", resp_cmd, exp.cmd);
            check_value("resp_dstaddr", resp_dstaddr, exp.dst);
            check_value("resp_srcaddr", resp_srcaddr, exp.src);
            check_value("resp_data", resp_data & exp.mask, exp.data);
         end
      end
   end

   initial begin : stimulus
      logic [2:0] size;
      logic [7:0] len;
      logic [2:0] offset;
      logic [4:0] opcode;
      clk         = 1'b0;
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      nreset = 1'b1;
      next_cycle();
      check_value("resp_valid", resp_valid, 1'b0);
      check_value("req_ready", req_ready, 1'b1);

      for (int w = 0; w < 16; w++)
         send_req(REQ_WRITE, 8'h00, 32'(w * 8), 3'd3, 8'd0, rand64());
      read_all();

      // Partial writes, posted and acknowledged
      for (int n = 0; n < 40; n++) begin
         pick_span(size, len, offset);
         opcode = (rand_below(2) == 0) ? REQ_POSTED : REQ_WRITE;
         send_req(opcode, 8'h00, 32'(rand_below(16) * 8 + offset), size, len, rand64());
      end
      read_all();

      for (int a = 0; a < 10; a++) begin
         for (int r = 0; r < 4; r++)
            send_atomic((a == 9) ? 8'h0c : 8'(a)); // 8'h0c is an unlisted code
      end
      read_all();

      // ####################
      // Back-pressure
      // ####################
      stall_en = 1'b1;
      for (int n = 0; n < 60; n++) begin
         pick_span(size, len, offset);
         case (rand_below(4))
            0: opcode = REQ_READ;
            1: opcode = REQ_WRITE;
            2: opcode = REQ_POSTED;
            default: opcode = REQ_ATOMIC;
         endcase
         if (opcode == REQ_ATOMIC)
            send_atomic(8'(rand_below(9)));
         else
            send_req(opcode, 8'h00, 32'(rand_below(16) * 8 + offset), size, len, rand64());
      end
      read_all();
      wait_drain();
      stall_en = 1'b0;

      $display("Errors: %0d in %0d checks", errors, checks);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_agent.f
+incdir+verilog
verilog/umi_pkg.sv
verilog/loc_if.sv
verilog/umi_endpoint.sv
verilog/mem_datapath.sv
verilog/mem_array.sv
verilog/mem_agent.sv
testbench/tb_mem_agent.sv
